// ==== ls_unit.f ====
+incdir+include
source/ls_pkg.sv
source/ls_fifo.sv
source/ls_address_gen.sv
source/ls_mem_sub_unit.sv
source/ls_load_align.sv
source/load_store_unit.sv
test/tb_load_store_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator and runs it.
# Exits non-zero unless the testbench reports success.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f ls_unit.f --top-module tb_load_store_unit -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Everything OK" \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

// ==== source/load_store_unit.sv ====
/*
 * Load/store unit top level.
 * Requests arrive under credit flow control, are queued in order and
 * dispatched to the local memory or the scratch region by address.
 * Loads write back in request order through wb_valid, wb_id, wb_data.
 */
module load_store_unit
    import ls_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  logic            req_load,
    input  logic            req_store,
    input  logic [2:0]      req_fn3,
    input  logic [XLEN-1:0] req_rs1,
    input  logic [11:0]     req_offset,
    input  logic [XLEN-1:0] req_data,
    input  id_t             req_id,
    input  logic            exc_ack,
    output logic            credit_return,
    output logic            exc_valid,
    output logic [3:0]      exc_code,
    output logic [XLEN-1:0] exc_tval,
    output id_t             exc_id,
    output logic            wb_valid,
    output id_t             wb_id,
    output logic [XLEN-1:0] wb_data,
    output logic            idle
);

    ls_request_t     queue_entry, head;
    logic            queue_push, queue_valid;
    load_attr_t      new_attr, wb_attr;
    logic            attr_push, attr_pop, attr_valid, attr_full;
    logic            head_local, head_scratch;
    logic            last_sel, switch_hold, dispatch;
    logic            local_ready, scratch_ready, local_valid, scratch_valid;
    logic [XLEN-1:0] local_data, scratch_data, load_data;
    logic [1:0]      size_sel;
    logic            exc_taken;
    logic [2:0]      credit_due, credit_owed;

    ls_address_gen addr_gen (
        .clk, .rst, .req_valid, .req_load, .req_store, .req_fn3, .req_rs1, .req_offset,
        .req_data, .req_id, .exc_ack, .queue_push, .queue_entry,
        .exc_valid, .exc_code, .exc_tval, .exc_id
    );

    ls_fifo #(.payload_t(ls_request_t), .DEPTH(REQ_QUEUE_DEPTH)) request_queue (
        .clk, .rst, .push(queue_push), .pop(dispatch), .data_in(queue_entry),
        .data_out(head), .valid(queue_valid), .full()
    );

    //////////////////////////////
    // Region decode and dispatch
    assign head_local   = (head.addr - LOCAL_BASE) < XLEN'(LOCAL_WORDS * 4);
    assign head_scratch = (head.addr - SCRATCH_BASE) < XLEN'(SCRATCH_WORDS * 4);

    // Results from the two sub-units must not overtake each other
    assign switch_hold = (head_scratch != last_sel) & attr_valid;
    assign dispatch = queue_valid & ~(head.load & attr_full) & local_ready & scratch_ready
                    & ~switch_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_sel <= 1'b0;
        end else if (attr_push) begin
            last_sel <= head_scratch;
        end
    end

    //////////////////////////////
    // Load attributes
    always_comb begin
        case (head.fn3)
            FN3_B, FN3_BU: size_sel = 2'd0;
            FN3_H, FN3_HU: size_sel = 2'd1;
            default:       size_sel = 2'd2;
        endcase
    end

    assign new_attr  = '{byte_addr: head.addr[1:0], is_signed: ~head.fn3[2],
                         size_sel: size_sel, id: head.id, sel: head_scratch};
    assign attr_push = dispatch & head.load;
    assign attr_pop  = local_valid | scratch_valid;

    ls_fifo #(.payload_t(load_attr_t), .DEPTH(ATTR_DEPTH)) attr_fifo (
        .clk, .rst, .push(attr_push), .pop(attr_pop), .data_in(new_attr),
        .data_out(wb_attr), .valid(attr_valid), .full(attr_full)
    );

    ls_mem_sub_unit #(.WORDS(LOCAL_WORDS), .LATENCY(LOCAL_LATENCY)) local_mem (
        .clk, .rst, .request(dispatch & head_local), .addr(head.addr), .load(head.load),
        .store(head.store), .be(head.be), .data_in(head.data),
        .ready(local_ready), .data_valid(local_valid), .data_out(local_data)
    );

    ls_mem_sub_unit #(.WORDS(SCRATCH_WORDS), .LATENCY(SCRATCH_LATENCY)) scratch_mem (
        .clk, .rst, .request(dispatch & head_scratch), .addr(head.addr), .load(head.load),
        .store(head.store), .be(head.be), .data_in(head.data),
        .ready(scratch_ready), .data_valid(scratch_valid), .data_out(scratch_data)
    );

    ls_load_align align (
        .sel(wb_attr.sel), .local_data, .scratch_data, .attr(wb_attr), .load_data
    );

    //////////////////////////////
    // Credits
    // A pop and an exception ack in one cycle owe two credits
    assign exc_taken     = exc_valid & exc_ack;
    assign credit_due    = 3'(dispatch) + 3'(exc_taken) + credit_owed;
    assign credit_return = (credit_due != 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_owed <= '0;
        end else begin
            credit_owed <= credit_due - 3'(credit_return);
        end
    end

    assign wb_valid = attr_pop;
    assign wb_id    = wb_attr.id;
    assign wb_data  = load_data;
    assign idle     = ~queue_valid & ~attr_valid;

    // Returning data must come from the sub-unit the oldest load went to
    wb_has_attr: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (attr_valid && wb_attr.sel == scratch_valid))
        else $error("writeback without matching load attribute");
    dispatch_in_range: assert property (@(posedge clk) disable iff (rst)
        dispatch |-> (head_local | head_scratch))
        else $error("dispatched address outside both regions");

endmodule

// ==== source/ls_address_gen.sv ====
/*
 * Address stage of the load/store unit.
 * Forms the effective address, checks alignment and builds byte enables.
 * Aligned requests are pushed into the request queue, misaligned ones
 * load the exception register until it is acknowledged.
 */
module ls_address_gen
    import ls_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  logic            req_load,
    input  logic            req_store,
    input  logic [2:0]      req_fn3,
    input  logic [XLEN-1:0] req_rs1,
    input  logic [11:0]     req_offset,
    input  logic [XLEN-1:0] req_data,
    input  id_t             req_id,
    input  logic            exc_ack,
    output logic            queue_push,
    output ls_request_t     queue_entry,
    output logic            exc_valid,
    output logic [3:0]      exc_code,
    output logic [XLEN-1:0] exc_tval,
    output id_t             exc_id
);

    logic [XLEN-1:0] eff_addr;
    logic            misaligned;
    logic            new_exc;
    logic [3:0]      be;
    logic [XLEN-1:0] store_data;

    assign eff_addr = req_rs1 + {{(XLEN-12){req_offset[11]}}, req_offset};

    //////////////////////////////
    // Alignment check
    always_comb begin
        case (req_fn3)
            FN3_H, FN3_HU: misaligned = eff_addr[0];
            FN3_W:         misaligned = |eff_addr[1:0];
            default:       misaligned = 1'b0;
        endcase
    end

    //////////////////////////////
    // Byte enables and lane replication
    always_comb begin
        be = 4'b0000;
        case (req_fn3[1:0])
            2'b00: begin
                be[eff_addr[1:0]] = 1'b1;
                store_data = {4{req_data[7:0]}};
            end
            2'b01: begin
                be = eff_addr[1] ? 4'b1100 : 4'b0011;
                store_data = {2{req_data[15:0]}};
            end
            default: begin
                be = 4'b1111;
                store_data = req_data;
            end
        endcase
    end

    assign queue_push  = req_valid & ~misaligned;
    assign queue_entry = '{addr: eff_addr, be: be, data: store_data, load: req_load,
                           store: req_store, fn3: req_fn3, id: req_id};

    //////////////////////////////
    // Exception register
    assign new_exc = req_valid & misaligned;

    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
        end else begin
            exc_valid <= (exc_valid & ~exc_ack) | new_exc;
        end
    end

    // Held until acknowledged
    always_ff @(posedge clk) begin
        if (new_exc) begin
            exc_code <= req_store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
            exc_tval <= eff_addr;
            exc_id   <= req_id;
        end
    end

endmodule

// ==== source/ls_fifo.sv ====
/*
 * Synchronous FIFO with a type parameter for its payload.
 * data_out shows the oldest entry while valid is high.
 * Used for the request queue and for the load attribute FIFO.
 */
module ls_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid,
    output logic     full
);

    payload_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign data_out = mem[rd_ptr];
    assign valid    = (count != 0);
    assign full     = (count == DEPTH);

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full FIFO");
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("pop from empty FIFO");

endmodule

// ==== source/ls_load_align.sv ====
/*
 * Load data alignment.
 * Picks the returning sub-unit's word, moves the addressed byte or
 * halfword to the low end and sign- or zero-extends it.
 */
module ls_load_align
    import ls_pkg::*;
(
    input  logic            sel,
    input  logic [XLEN-1:0] local_data,
    input  logic [XLEN-1:0] scratch_data,
    input  load_attr_t      attr,
    output logic [XLEN-1:0] load_data
);

    logic [XLEN-1:0] raw;
    logic [7:0]      byte_field;
    logic [15:0]     half_field;
    logic            sign_bit;

    assign raw = sel ? scratch_data : local_data;

    // Accesses are aligned, so a halfword sits in one half of the word
    assign byte_field = raw[attr.byte_addr*8 +: 8];
    assign half_field = attr.byte_addr[1] ? raw[31:16] : raw[15:0];

    always_comb begin
        case (attr.size_sel)
            2'd0: begin
                sign_bit  = attr.is_signed & byte_field[7];
                load_data = {{24{sign_bit}}, byte_field};
            end
            2'd1: begin
                sign_bit  = attr.is_signed & half_field[15];
                load_data = {{16{sign_bit}}, half_field};
            end
            default: begin
                sign_bit  = 1'b0;
                load_data = raw;
            end
        endcase
    end

endmodule

// ==== source/ls_mem_sub_unit.sv ====
/*
 * Word-wide memory sub-unit with byte-enabled writes.
 * Read data passes through a LATENCY stage delay line, so a new read
 * can start every cycle while earlier ones are still in flight.
 */
module ls_mem_sub_unit
    import ls_pkg::*;
#(
    parameter int WORDS   = 1024,
    parameter int LATENCY = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            request,
    input  logic [XLEN-1:0] addr,
    input  logic            load,
    input  logic            store,
    input  logic [3:0]      be,
    input  logic [XLEN-1:0] data_in,
    output logic            ready,
    output logic            data_valid,
    output logic [XLEN-1:0] data_out
);

    logic [XLEN-1:0]            mem [WORDS];
    logic [$clog2(WORDS)-1:0]   word_idx;
    logic [LATENCY-1:0]         valid_pipe;
    logic [XLEN-1:0]            data_pipe [LATENCY];

    // Region base is aligned to its size, so low bits index the array
    assign word_idx = addr[$clog2(WORDS)+1:2];

    always_ff @(posedge clk) begin
        if (request & store) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[word_idx][b*8 +: 8] <= data_in[b*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Read delay line
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[word_idx];
        for (int i = 1; i < LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= request & load;
            for (int i = 1; i < LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign ready      = 1'b1;
    assign data_valid = valid_pipe[LATENCY-1];
    assign data_out   = data_pipe[LATENCY-1];

    one_op_per_request: assert property (@(posedge clk) disable iff (rst)
        request |-> (load ^ store)) else $error("request needs exactly one of load/store");

endmodule

// ==== source/ls_pkg.sv ====
/*
 * Shared definitions for the load/store unit.
 * Widths, funct3 codes, exception codes, the address map of both memory
 * sub-units, queue depths and the request and load attribute structs.
 */
package ls_pkg;

    localparam int XLEN = 32;
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] id_t;

    // RISC-V load/store funct3 encodings
    localparam logic [2:0] FN3_B  = 3'b000;
    localparam logic [2:0] FN3_H  = 3'b001;
    localparam logic [2:0] FN3_W  = 3'b010;
    localparam logic [2:0] FN3_BU = 3'b100;
    localparam logic [2:0] FN3_HU = 3'b101;

    localparam logic [3:0] EXC_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] EXC_STORE_MISALIGNED = 4'd6;

    // Address map
    localparam logic [XLEN-1:0] LOCAL_BASE   = 32'h0000_0000;
    localparam int              LOCAL_WORDS  = 1024;
    localparam logic [XLEN-1:0] SCRATCH_BASE = 32'h0001_0000;
    localparam int              SCRATCH_WORDS = 64;

    localparam int LOCAL_LATENCY   = 1;
    localparam int SCRATCH_LATENCY = 2;

    // Queue depth doubles as the issuer's credit count
    localparam int REQ_QUEUE_DEPTH = 4;
    localparam int ATTR_DEPTH      = 2;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [3:0]      be;
        logic [XLEN-1:0] data;
        logic            load;
        logic            store;
        logic [2:0]      fn3;
        id_t             id;
    } ls_request_t;

    typedef struct packed {
        logic [1:0] byte_addr;
        logic       is_signed;
        logic [1:0] size_sel;   // 0 byte, 1 halfword, 2 word
        id_t        id;
        logic       sel;        // Set for the scratch sub-unit
    } load_attr_t;

endpackage

// ==== include/ls_tb_ref.svh ====
/*
 * Reference model for the load/store unit testbench.
 * Included inside the testbench module. Keeps a byte image of both
 * memory regions and computes the value that a load must write back.
 */
`ifndef LS_TB_REF_SVH
`define LS_TB_REF_SVH

// Byte image of local memory and scratch region keyed by address
logic [7:0] model_mem [logic [XLEN-1:0]];

function automatic int access_bytes(input logic [2:0] fn3);
    case (fn3[1:0])
        2'b00:   return 1;
        2'b01:   return 2;
        default: return 4;
    endcase
endfunction

// Low bytes of the store data go to ascending addresses
task automatic write_model(input logic [XLEN-1:0] addr, input logic [2:0] fn3,
                           input logic [XLEN-1:0] data);
    for (int i = 0; i < access_bytes(fn3); i++) begin
        model_mem[addr + XLEN'(i)] = data[i*8 +: 8];
    end
endtask

function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] addr,
                                                  input logic [2:0] fn3);
    logic [XLEN-1:0] value;
    int              nbytes;
    value  = '0;
    nbytes = access_bytes(fn3);
    for (int i = 0; i < nbytes; i++) begin
        value[i*8 +: 8] = model_mem.exists(addr + XLEN'(i)) ? model_mem[addr + XLEN'(i)] : 8'hxx;
    end
    // Signed loads copy the top bit read into the upper bits
    if (!fn3[2] && nbytes < 4) begin
        for (int i = nbytes * 8; i < XLEN; i++) begin
            value[i] = value[nbytes*8 - 1];
        end
    end
    return value;
endfunction

`endif

// ==== test/tb_load_store_unit.sv ====
/*
 * Testbench for the load/store unit.
 * Issues requests under credit flow control, checks every writeback and
 * exception against the byte model, then prints a per-test report.
 */
module tb_load_store_unit
    import ls_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 200;
    // Requests issued over all tests
    localparam int TOTAL_REQS = 28 + 26 + 16 + N_RANDOM + 28;

    logic            clk, rst, req_valid, req_load, req_store, exc_ack;
    logic [2:0]      req_fn3;
    logic [XLEN-1:0] req_rs1, req_data;
    logic [11:0]     req_offset;
    id_t             req_id;
    logic            credit_return, exc_valid, wb_valid, idle;
    logic [3:0]      exc_code;
    logic [XLEN-1:0] exc_tval, wb_data;
    id_t             exc_id, wb_id;

    int              issued = 0;
    int              returned = 0;
    int              check_errors = 0;
    int              stim_errors, tests_run, tests_failed;
    id_t             next_id;
    logic [2:0]      fn3_codes [5] = '{FN3_B, FN3_H, FN3_W, FN3_BU, FN3_HU};
    logic [XLEN-1:0] exp_data_q [$];
    id_t             exp_id_q [$];
    logic [XLEN+7:0] exp_exc_q [$];   // {code, id, tval}

    `include "ls_tb_ref.svh"

    load_store_unit uut (
        .clk, .rst, .req_valid, .req_load, .req_store, .req_fn3, .req_rs1, .req_offset,
        .req_data, .req_id, .exc_ack, .credit_return, .exc_valid, .exc_code, .exc_tval,
        .exc_id, .wb_valid, .wb_id, .wb_data, .idle
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic value_error(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        $display("** Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    //////////////////////////////
    // Response checker
    always @(posedge clk) begin
        if (!rst) begin
            if (credit_return) begin
                if (returned >= issued) begin
                    $display("Credit returned at time %0t with no request outstanding", $time);
                    check_errors++;
                end
                returned++;
            end
            // A pending writeback means the attribute FIFO is not empty
            if (wb_valid && idle !== 1'b0) begin
                value_error("idle", XLEN'(idle), '0);
                check_errors++;
            end
            if (wb_valid) begin
                if (exp_data_q.size() == 0) begin
                    $display("Writeback at time %0t with no load outstanding", $time);
                    check_errors++;
                end else begin
                    if (wb_id !== exp_id_q[0]) begin
                        value_error("wb_id", XLEN'(wb_id), XLEN'(exp_id_q[0]));
                        check_errors++;
                    end
                    if (wb_data !== exp_data_q[0]) begin
                        value_error("wb_data", wb_data, exp_data_q[0]);
                        check_errors++;
                    end
                    void'(exp_data_q.pop_front());
                    void'(exp_id_q.pop_front());
                end
            end
            if (exc_valid && exc_ack) begin
                if (exp_exc_q.size() == 0) begin
                    $display("Exception at time %0t for a request that was aligned", $time);
                    check_errors++;
                end else begin
                    if (exc_code !== exp_exc_q[0][XLEN+7:XLEN+4]) begin
                        value_error("exc_code", XLEN'(exc_code),
                                    XLEN'(exp_exc_q[0][XLEN+7:XLEN+4]));
                        check_errors++;
                    end
                    if (exc_id !== exp_exc_q[0][XLEN+3:XLEN]) begin
                        value_error("exc_id", XLEN'(exc_id), XLEN'(exp_exc_q[0][XLEN+3:XLEN]));
                        check_errors++;
                    end
                    if (exc_tval !== exp_exc_q[0][XLEN-1:0]) begin
                        value_error("exc_tval", exc_tval, exp_exc_q[0][XLEN-1:0]);
                        check_errors++;
                    end
                    void'(exp_exc_q.pop_front());
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus helpers
    function automatic logic is_misaligned(input logic [2:0] fn3, input logic [XLEN-1:0] addr);
        if (fn3[1:0] == 2'b01) begin
            return addr[0];
        end
        if (fn3[1:0] == 2'b10) begin
            return addr[1:0] != 2'b00;
        end
        return 1'b0;
    endfunction

    function automatic logic [XLEN-1:0] word_addr(input logic scratch, input int idx);
        return (scratch ? SCRATCH_BASE : LOCAL_BASE) + XLEN'(idx * 4);
    endfunction

    function automatic logic [1:0] random_lane(input logic [2:0] fn3);
        logic [1:0] lane;
        lane = 2'($urandom_range(3));
        if (fn3[1:0] == 2'b01) begin
            lane[0] = 1'b0;
        end
        if (fn3[1:0] == 2'b10) begin
            lane = 2'b00;
        end
        return lane;
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic issue(input logic load, input logic [2:0] fn3,
                         input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        int   offset;
        logic bad;
        while (issued - returned >= REQ_QUEUE_DEPTH || exc_valid) begin
            @(negedge clk);
        end
        offset     = int'($urandom_range(255)) - 128;
        bad        = is_misaligned(fn3, addr);
        req_load   = load;
        req_store  = ~load;
        req_fn3    = fn3;
        req_rs1    = addr - XLEN'(offset);
        req_offset = 12'(offset);
        req_data   = data;
        req_id     = next_id;
        req_valid  = 1'b1;
        issued++;
        if (bad) begin
            exp_exc_q.push_back({load ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED, next_id, addr});
        end else if (load) begin
            exp_data_q.push_back(expected_load(addr, fn3));
            exp_id_q.push_back(next_id);
        end else begin
            write_model(addr, fn3, data);
        end
        next_id++;
        @(negedge clk);
        req_valid = 1'b0;
        if (bad) begin
            while (!exc_valid) begin
                @(negedge clk);
            end
            exc_ack = 1'b1;
            @(negedge clk);
            exc_ack = 1'b0;
        end
    endtask

    task automatic check_reset_value(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_error(name, XLEN'(got), XLEN'(exp));
            stim_errors++;
        end
    endtask

    // Waits for all results and credits, then reports the test
    task automatic end_test(input string name, input int errors_before);
        int errs;
        while (exp_data_q.size() != 0 || exp_exc_q.size() != 0
               || !idle || returned < issued) begin
            @(negedge clk);
        end
        errs = check_errors + stim_errors - errors_before;
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errs);
        end
    endtask

    //////////////////////////////
    // Test sequence
    initial begin
        int              base;
        logic            load;
        logic [2:0]      fn3;
        logic [XLEN-1:0] addr;
        void'($urandom(6));
        clk = 1'b0;
        rst = 1'b1;
        {req_valid, req_load, req_store, exc_ack} = 4'b0000;
        req_fn3 = FN3_W;
        req_rs1 = '0;
        req_offset = '0;
        req_data = '0;
        req_id = '0;
        next_id = '0;
        stim_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        base = 0;
        check_reset_value("idle", idle, 1'b1);
        check_reset_value("wb_valid", wb_valid, 1'b0);
        check_reset_value("exc_valid", exc_valid, 1'b0);
        check_reset_value("credit_return", credit_return, 1'b0);
        end_test("reset state", base);

        // Every load width and offset after a word store
        base = check_errors + stim_errors;
        for (int round = 0; round < 2; round++) begin
            addr = word_addr(1'b0, 16 + round);
            issue(1'b0, FN3_W, addr, $urandom());
            for (int k = 0; k < 4; k++) begin
                issue(1'b1, FN3_B, addr + XLEN'(k), '0);
                issue(1'b1, FN3_BU, addr + XLEN'(k), '0);
            end
            for (int k = 0; k < 4; k += 2) begin
                issue(1'b1, FN3_H, addr + XLEN'(k), '0);
                issue(1'b1, FN3_HU, addr + XLEN'(k), '0);
            end
            issue(1'b1, FN3_W, addr, '0);
        end
        end_test("load widths and offsets", base);

        // Partial stores read back as words
        base = check_errors + stim_errors;
        for (int region = 0; region < 2; region++) begin
            addr = word_addr(region != 0, 8);
            issue(1'b0, FN3_W, addr, $urandom());
            for (int k = 0; k < 4; k++) begin
                issue(1'b0, FN3_B, addr + XLEN'(k), $urandom());
                issue(1'b1, FN3_W, addr, '0);
            end
            for (int k = 0; k < 4; k += 2) begin
                issue(1'b0, FN3_H, addr + XLEN'(k), $urandom());
                issue(1'b1, FN3_W, addr, '0);
            end
        end
        end_test("partial stores", base);

        base = check_errors + stim_errors;
        for (int k = 0; k < 16; k++) begin
            issue(1'b0, FN3_W, word_addr(k >= 8, k % 8), $urandom());
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            load = 1'($urandom_range(1));
            fn3  = fn3_codes[$urandom_range(load ? 4 : 2)];
            addr = word_addr(1'($urandom_range(1)), int'($urandom_range(7)));
            issue(load, fn3, addr + XLEN'(random_lane(fn3)), $urandom());
        end
        end_test("random stream", base);

        // Misaligned accesses must leave memory untouched
        base = check_errors + stim_errors;
        for (int region = 0; region < 2; region++) begin
            addr = word_addr(region != 0, 36);
            issue(1'b0, FN3_W, addr, $urandom());
            for (int k = 1; k < 4; k++) begin
                issue(1'b1, FN3_W, addr + XLEN'(k), '0);
                issue(1'b0, FN3_W, addr + XLEN'(k), $urandom());
                if (k != 2) begin
                    issue(1'b1, FN3_H, addr + XLEN'(k), '0);
                    issue(1'b1, FN3_HU, addr + XLEN'(k), '0);
                    issue(1'b0, FN3_H, addr + XLEN'(k), $urandom());
                end
            end
            issue(1'b1, FN3_W, addr, '0);
        end
        end_test("misaligned accesses", base);

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, check_errors + stim_errors);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized at 20 cycles per request plus margin
    initial begin
        #((20 * TOTAL_REQS + 100) * CLK_PERIOD);
        $display("Timeout after %0d cycles, results or credits never arrived",
                 20 * TOTAL_REQS + 100);
        $display("Something failed");
        $finish;
    end

endmodule
